/* ppu_consts.svh */
/*
 * Widths, register timing lines, palette page and address steps
 * shared by the picture processor register blocks
 */
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// Bus and counter widths
`define PPU_ADDR_W   15 // VRAM address register, bus uses low 14
`define PPU_LINE_W   9  // Scanline and cycle
`define PPU_DATA_W   8  // CPU data bus
`define PPU_COLOR_W  6  // One palette entry

// Line timing
`define PPU_LAST_CYCLE      340
`define PPU_PRE_RENDER_LINE 511 // Line -1 in 9 bits
`define PPU_VBL_START_NTSC  241 // Also PAL and Vs.
`define PPU_VBL_START_DENDY 291
`define PPU_VBL_END_NTSC    260 // Also Vs.
`define PPU_VBL_END_PAL     310 // Also Dendy

`define PPU_PAL_PAGE   6'b111111 // Address bits 13:8 of palette space
`define PPU_INC_ACROSS 1
`define PPU_INC_DOWN   32

`endif

/* ppu_timing_pkg.sv */
/*
 * System type and counter types for the frame timing
 */
`include "ppu_consts.svh"

package ppu_timing_pkg;

	// Console variants, encoding follows the sys_type pins
	typedef enum logic [1:0] {
		SYS_NTSC  = 2'd0,
		SYS_PAL   = 2'd1,
		SYS_DENDY = 2'd2,
		SYS_VS    = 2'd3
	} sys_type_t;

	// Scanline or cycle count
	typedef logic [`PPU_LINE_W-1:0] line_t;

endpackage

/* ppu_bus_pkg.sv */
/*
 * CPU register indices and the field types seen on the CPU side
 * and on the VRAM address bus
 */
`include "ppu_consts.svh"

package ppu_bus_pkg;

	// Register select on ain, indices 3 to 5 are not decoded here
	typedef enum logic [2:0] {
		REG_CTRL   = 3'd0, // $2000
		REG_MASK   = 3'd1, // $2001
		REG_STATUS = 3'd2, // $2002
		REG_ADDR   = 3'd6, // $2006
		REG_DATA   = 3'd7  // $2007
	} reg_index_t;

	typedef logic [`PPU_DATA_W-1:0]  cpu_byte_t;
	typedef logic [`PPU_ADDR_W-1:0]  vram_addr_t; // Bit 14 only lives in the temp register
	typedef logic [`PPU_COLOR_W-1:0] color_t;

endpackage

/* frame_timer.sv */
/*
 * Cycle and scanline counters with vblank start and end events
 * and the vblank flag
 */
`timescale 1ns/1ps
`include "ppu_consts.svh"

module frame_timer
	import ppu_timing_pkg::*;
(
	input  logic      clk,
	input  logic      ce,
	input  logic      reset,
	input  sys_type_t sys_type,
	output line_t     scanline,
	output line_t     cycle,
	output logic      is_in_vblank,
	output logic      entering_vblank, // One cycle at cycle 0 of the start line
	output logic      exiting_vblank   // One cycle at cycle 0 of the pre-render line
);

	line_t vbl_start_line;
	line_t vbl_end_line;  // Last line before pre-render
	logic  end_of_line;

	// Dendy starts late, PAL and Dendy both end at 310
	always_comb begin
		case (sys_type)
			SYS_PAL: begin
				vbl_start_line = line_t'(`PPU_VBL_START_NTSC);
				vbl_end_line   = line_t'(`PPU_VBL_END_PAL);
			end
			SYS_DENDY: begin
				vbl_start_line = line_t'(`PPU_VBL_START_DENDY);
				vbl_end_line   = line_t'(`PPU_VBL_END_PAL);
			end
			default: begin // NTSC and Vs.
				vbl_start_line = line_t'(`PPU_VBL_START_NTSC);
				vbl_end_line   = line_t'(`PPU_VBL_END_NTSC);
			end
		endcase
	end

	assign end_of_line     = (cycle == line_t'(`PPU_LAST_CYCLE));
	assign entering_vblank = (cycle == '0) && (scanline == vbl_start_line);
	assign exiting_vblank  = (cycle == '0) && (scanline == line_t'(`PPU_PRE_RENDER_LINE));

	always_ff @(posedge clk) begin
		if (reset) begin
			cycle        <= '0;
			scanline     <= '0;
			is_in_vblank <= 1'b0;
		end else if (ce) begin
			cycle <= end_of_line ? '0 : cycle + 1'b1;
			if (end_of_line) begin
				// Jump to line -1 after the end line, 511 + 1 wraps to 0
				scanline <= (scanline == vbl_end_line) ?
					line_t'(`PPU_PRE_RENDER_LINE) : scanline + 1'b1;
			end
			if (entering_vblank)
				is_in_vblank <= 1'b1;
			else if (exiting_vblank)
				is_in_vblank <= 1'b0;
		end
	end

	// The line never runs past 341 cycles
	a_cycle_range: assert property (@(posedge clk) disable iff (reset)
		cycle <= line_t'(`PPU_LAST_CYCLE));

endmodule

/* vram_addr_reg.sv */
/*
 * $2006 address register: temp register, write latch,
 * active address with increment after each data port access
 */
`timescale 1ns/1ps
`include "ppu_consts.svh"

module vram_addr_reg
	import ppu_bus_pkg::*;
(
	input  logic       clk,
	input  logic       ce,
	input  logic       reset,
	input  reg_index_t ain,
	input  cpu_byte_t  din,
	input  logic       write,
	input  logic       status_read,   // Clears the write latch
	input  logic       data_access,   // CPU read or write of $2007
	input  logic       addr_inc_down, // Step 32 instead of 1
	output vram_addr_t vram_addr,
	output logic       is_pal_address
);

	vram_addr_t temp_addr; // Collects the two halves
	logic       write_latch; // 0 = high byte next

	always_ff @(posedge clk) begin
		if (reset) begin
			write_latch <= 1'b0;
			vram_addr   <= '0;
		end else if (ce) begin
			if (write && ain == REG_ADDR) begin
				if (!write_latch) begin
					temp_addr[13:8] <= din[5:0];
					temp_addr[14]   <= 1'b0; // Top bit is always cleared by the first write
				end else begin
					temp_addr[7:0] <= din;
					vram_addr      <= {temp_addr[14:8], din}; // Second write commits
				end
				write_latch <= !write_latch;
			end else if (status_read) begin
				write_latch <= 1'b0; // Restart the two-write sequence
			end else if (data_access) begin
				vram_addr <= vram_addr + (addr_inc_down ?
					vram_addr_t'(`PPU_INC_DOWN) : vram_addr_t'(`PPU_INC_ACROSS));
			end
		end
	end

	// $3F00 to $3FFF and mirrors above
	assign is_pal_address = (vram_addr[13:8] == `PPU_PAL_PAGE);

endmodule

/* palette_ram.sv */
/*
 * 32-entry palette storage, backdrop entries mirrored
 */
`timescale 1ns/1ps

module palette_ram
	import ppu_bus_pkg::*;
(
	input  logic       clk,
	input  logic       ce,
	input  logic [4:0] addr,
	input  logic       write,
	input  color_t     wdata,
	output color_t     color  // Asynchronous read
);

	// Power-on contents
	color_t pal_mem [32] = '{
		6'h0F, 6'h2C, 6'h10, 6'h1C,
		6'h0F, 6'h37, 6'h27, 6'h07,
		6'h0F, 6'h28, 6'h16, 6'h07,
		6'h0F, 6'h28, 6'h0F, 6'h2C,
		6'h0F, 6'h0F, 6'h2C, 6'h11,
		6'h0F, 6'h0F, 6'h20, 6'h38,
		6'h0F, 6'h0F, 6'h15, 6'h27,
		6'h0F, 6'h0F, 6'h11, 6'h3C
	};

	logic [4:0] index;

	// Sprite backdrops 0x10/14/18/1C share storage with 0x00/04/08/0C
	assign index = (addr[1:0] == 2'b00) ? {1'b0, addr[3:0]} : addr;

	always_ff @(posedge clk) begin
		if (ce && write)
			pal_mem[index] <= wdata;
	end

	assign color = pal_mem[index];

endmodule

/* ppu_regs.sv */
/*
 * Control, mask and status registers, NMI, VRAM strobes,
 * delayed read buffer and the CPU read data latch
 */
`timescale 1ns/1ps

module ppu_regs
	import ppu_bus_pkg::*;
(
	input  logic       clk,
	input  logic       ce,
	input  logic       reset,
	input  reg_index_t ain,
	input  cpu_byte_t  din,
	input  logic       read,
	input  logic       write,
	input  logic       pre_read,  // Early read strobe, drives vram_r
	input  logic       pre_write, // Early write strobe, drives vram_w
	input  logic       is_in_vblank,
	input  logic       entering_vblank,
	input  logic       exiting_vblank,
	input  cpu_byte_t  vram_din,
	input  logic       is_pal_address,
	input  color_t     color,     // Palette entry at the current address
	output cpu_byte_t  dout,
	output logic       nmi,
	output logic       vram_r,
	output logic       vram_w,
	output logic       status_read,
	output logic       data_access,
	output logic       addr_inc_down,
	output logic       pal_write
);

	logic      vbl_enable; // $2000 bit 7
	logic      grayscale;  // $2001 bit 0
	logic      nmi_flag;   // Vblank flag seen in status bit 7
	logic      read_delayed;
	cpu_byte_t read_buffer;

	assign status_read = read && (ain == REG_STATUS);
	assign data_access = (read || write) && (ain == REG_DATA);
	assign vram_r      = pre_read && (ain == REG_DATA);
	assign vram_w      = pre_write && (ain == REG_DATA) && !is_pal_address; // Palette stays internal
	assign pal_write   = write && (ain == REG_DATA) && is_pal_address;
	assign nmi         = nmi_flag && vbl_enable;

	always_ff @(posedge clk) begin
		if (reset) begin
			vbl_enable    <= 1'b0;
			addr_inc_down <= 1'b0;
			grayscale     <= 1'b0;
			nmi_flag      <= 1'b0;
		end else if (ce) begin
			if (write && ain == REG_CTRL) begin
				vbl_enable    <= din[7];
				addr_inc_down <= din[2];
			end
			if (write && ain == REG_MASK)
				grayscale <= din[0];
			// A status read in the same cycle as the start wins
			if (exiting_vblank || status_read)
				nmi_flag <= 1'b0;
			else if (entering_vblank)
				nmi_flag <= 1'b1;
			else if (!is_in_vblank)
				nmi_flag <= 1'b0; // Flag never outlives the vblank window
		end
	end

	// VRAM answers one cycle after vram_r
	always_ff @(posedge clk) begin
		if (reset)
			read_delayed <= 1'b0;
		else if (ce)
			read_delayed <= vram_r;
	end

	always_ff @(posedge clk) begin
		if (ce && read_delayed)
			read_buffer <= vram_din;
	end

	// CPU read latch, holds until the next access
	always_ff @(posedge clk) begin
		if (reset) begin
			dout <= '0;
		end else if (ce) begin
			if (write) begin
				dout <= din;
			end else if (read) begin
				case (ain)
					REG_STATUS: dout <= {nmi_flag, 2'b00, dout[4:0]}; // No sprite bits
					REG_DATA: begin
						if (is_pal_address)
							dout <= {dout[7:6], grayscale ? {color[5:4], 4'b0000} : color};
						else
							dout <= read_buffer; // Byte from the previous access
					end
					default: dout <= dout;
				endcase
			end
		end
	end

	// Read and write strobes never overlap on the bus
	a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
		!(vram_r && vram_w));

endmodule

/* ppu_core.sv */
/*
 * Picture processor CPU side: frame timer, address register,
 * palette RAM and register block
 */
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppu_core
	import ppu_timing_pkg::*;
	import ppu_bus_pkg::*;
(
	input  logic        clk,
	input  logic        ce,
	input  logic        reset,
	input  sys_type_t   sys_type,
	input  cpu_byte_t   din,
	input  reg_index_t  ain,
	input  logic        read,
	input  logic        write,
	input  logic        pre_read,
	input  logic        pre_write,
	input  cpu_byte_t   vram_din,
	output cpu_byte_t   dout,
	output logic        nmi,
	output logic        vram_r,
	output logic        vram_w,
	output logic [13:0] vram_a,
	output cpu_byte_t   vram_dout,
	output line_t       scanline,
	output line_t       cycle
);

	logic       is_in_vblank, entering_vblank, exiting_vblank;
	logic       status_read, data_access, addr_inc_down, pal_write;
	logic       is_pal_address;
	vram_addr_t vram_addr;
	color_t     color;

	assign vram_a    = vram_addr[13:0]; // Bit 14 is not on the bus
	assign vram_dout = din;

	frame_timer u_timer (
		.clk, .ce, .reset, .sys_type, .scanline, .cycle,
		.is_in_vblank, .entering_vblank, .exiting_vblank
	);

	vram_addr_reg u_addr (
		.clk, .ce, .reset, .ain, .din, .write, .status_read,
		.data_access, .addr_inc_down, .vram_addr, .is_pal_address
	);

	palette_ram u_palette (
		.clk, .ce, .addr(vram_addr[4:0]), .write(pal_write),
		.wdata(din[`PPU_COLOR_W-1:0]), .color
	);

	ppu_regs u_regs (
		.clk, .ce, .reset, .ain, .din, .read, .write, .pre_read, .pre_write,
		.is_in_vblank, .entering_vblank, .exiting_vblank, .vram_din,
		.is_pal_address, .color, .dout, .nmi, .vram_r, .vram_w,
		.status_read, .data_access, .addr_inc_down, .pal_write
	);

endmodule

/* ppu_core_checker.sv */
/*
 * Checker for the PPU core: read data, VRAM read and write strobes,
 * vblank start line and the jump to the pre-render line
 */
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppu_core_checker
	import ppu_timing_pkg::*;
	import ppu_bus_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  sys_type_t   sys_type,
	input  reg_index_t  ain,
	input  cpu_byte_t   din,
	input  cpu_byte_t   dout,
	input  logic        nmi,
	input  logic        vram_r,
	input  logic        vram_w,
	input  logic [13:0] vram_a,
	input  cpu_byte_t   vram_dout,
	input  line_t       scanline,
	input  line_t       cycle,
	input  logic        check_en,  // Access in this cycle carries a check
	input  logic [3:0]  check_op,
	input  logic [15:0] check_exp,
	output int          test_count,
	output int          error_count
);

	localparam logic [3:0] OP_READ       = 4'h1;
	localparam logic [3:0] OP_VRAM_WRITE = 4'h4;
	localparam logic [3:0] OP_PRIME      = 4'h5;
	localparam line_t      PRE_LINE      = line_t'(`PPU_PRE_RENDER_LINE);
	localparam line_t      LAST_CYCLE    = line_t'(`PPU_LAST_CYCLE);

	int         tests = 0;
	int         errors = 0;
	line_t      start_line;
	line_t      end_line;
	logic       read_pending = 1'b0;
	reg_index_t read_ain;
	cpu_byte_t  read_exp;
	logic       nmi_prev = 1'b0;
	line_t      prev_line = '0;
	line_t      prev_cycle = '0;

	assign test_count  = tests;
	assign error_count = errors;

	// Vblank lines per console: Dendy starts late, PAL and Dendy end late
	assign start_line = (sys_type == SYS_DENDY) ?
		line_t'(`PPU_VBL_START_DENDY) : line_t'(`PPU_VBL_START_NTSC);
	assign end_line = (sys_type == SYS_PAL || sys_type == SYS_DENDY) ?
		line_t'(`PPU_VBL_END_PAL) : line_t'(`PPU_VBL_END_NTSC);

	task automatic value_error(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp);
		errors++;
	endtask

	task automatic text_error(input string what);
		$display("Test %0d failed at %0t ns: %s", tests, $time, what);
		errors++;
	endtask

	// Samples before the edge, so DUT flops still show their old values
	always @(posedge clk) begin
		if (read_pending) begin // dout moved on the previous edge
			tests++;
			if (dout !== read_exp)
				value_error("dout", 16'(dout), 16'(read_exp));
			else if (read_ain == REG_STATUS && nmi)
				text_error("nmi stayed high after a status read");
			else
				$display("[PASS] test %0d: read of register %0d gave %h", tests, read_ain, dout);
		end
		read_pending <= check_en && check_op == OP_READ;
		read_ain     <= ain;
		read_exp     <= check_exp[7:0];

		if (check_en && check_op == OP_VRAM_WRITE) begin
			tests++;
			if (!vram_w)
				text_error("vram_w stayed low on a data port write");
			else if (vram_a !== check_exp[13:0])
				value_error("vram_a", 16'(vram_a), check_exp);
			else if (vram_dout !== din)
				value_error("vram_dout", 16'(vram_dout), 16'(din));
			else
				$display("[PASS] test %0d: VRAM write %h at %h", tests, vram_dout, vram_a);
		end else if (vram_w) begin
			tests++;
			text_error("vram_w rose outside a checked data port write");
		end

		// Data reads outside palette space fetch from VRAM, nothing else may
		if (check_en && (check_op == OP_READ || check_op == OP_PRIME) && ain == REG_DATA) begin
			if (!vram_r && vram_a[13:8] != `PPU_PAL_PAGE)
				text_error("vram_r stayed low on a data port read");
		end else if (vram_r) begin
			text_error("vram_r rose without a data port read");
		end

		if (reset) begin
			nmi_prev   <= 1'b0;
			prev_line  <= '0;
			prev_cycle <= '0;
		end else begin
			nmi_prev   <= nmi;
			prev_line  <= scanline;
			prev_cycle <= cycle;
			if (nmi && !nmi_prev) begin // Vblank start as seen on nmi
				tests++;
				if (scanline !== start_line)
					value_error("scanline at nmi rise", 16'(scanline), 16'(start_line));
				else if (cycle !== line_t'(1))
					value_error("cycle at nmi rise", 16'(cycle), 16'd1);
				else
					$display("[PASS] test %0d: nmi rose on line %0d", tests, scanline);
			end
			if (scanline == PRE_LINE && prev_line != PRE_LINE) begin
				tests++;
				if (prev_line !== end_line)
					value_error("scanline before pre-render", 16'(prev_line), 16'(end_line));
				else if (prev_cycle !== LAST_CYCLE)
					value_error("cycle before pre-render", 16'(prev_cycle), 16'(LAST_CYCLE));
				else if (cycle !== '0)
					value_error("cycle at pre-render", 16'(cycle), 16'd0);
				else
					$display("[PASS] test %0d: line %0d went to pre-render", tests, prev_line);
			end
		end
	end

endmodule

/* ppu_core_tb.sv */
/*
 * Testbench top for the PPU core: clock, reset, stim file driver,
 * VRAM model and the checker instance
 */
`timescale 1ns/1ps

module ppu_core_tb
	import ppu_timing_pkg::*;
	import ppu_bus_pkg::*;
();

	localparam int VBL_TIMEOUT = 120000; // Cycles, more than one PAL frame
	localparam int STIM_WORDS  = 256;

	logic        clk = 1'b0;
	logic        ce;
	logic        reset;
	sys_type_t   sys_type;
	cpu_byte_t   din;
	reg_index_t  ain;
	logic        read;
	logic        write;
	logic        pre_read;
	logic        pre_write;
	cpu_byte_t   vram_din = 8'h00;
	cpu_byte_t   dout;
	logic        nmi;
	logic        vram_r;
	logic        vram_w;
	logic [13:0] vram_a;
	cpu_byte_t   vram_dout;
	line_t       scanline;
	line_t       cycle;

	logic        check_en;  // Current access carries a check
	logic [3:0]  check_op;
	logic [15:0] check_exp;
	int          test_count;
	int          error_count;
	logic        aborted;   // Timeout or bad stim line
	int          vram_writes = 0;

	logic [15:0] stim_mem [STIM_WORDS]; // Four words per access: op, ain, data, expected

	always #50 clk = ~clk;

	ppu_core UUT (
		.clk, .ce, .reset, .sys_type, .din, .ain, .read, .write, .pre_read, .pre_write,
		.vram_din, .dout, .nmi, .vram_r, .vram_w, .vram_a, .vram_dout, .scanline, .cycle
	);

	ppu_core_checker u_check (
		.clk, .reset, .sys_type, .ain, .din, .dout, .nmi, .vram_r, .vram_w, .vram_a,
		.vram_dout, .scanline, .cycle, .check_en, .check_op, .check_exp, .test_count,
		.error_count
	);

	// VRAM model answers one clock after vram_r, counts bus writes
	always @(posedge clk) begin
		if (vram_r)
			vram_din <= vram_a[7:0] ^ 8'h5A;
		if (vram_w)
			vram_writes <= vram_writes + 1;
	end

	// One CPU access, then an idle cycle so the read buffer can fill
	task automatic cpu_access(input logic is_write, input logic [3:0] op,
			input logic [2:0] a, input cpu_byte_t d, input logic [15:0] e);
		ain       = reg_index_t'(a);
		din       = d;
		write     = is_write;
		pre_write = is_write; // Early strobes always go with the late ones
		read      = !is_write;
		pre_read  = !is_write;
		check_en  = 1'b1;
		check_op  = op;
		check_exp = e;
		@(negedge clk);
		read      = 1'b0;
		write     = 1'b0;
		pre_read  = 1'b0;
		pre_write = 1'b0;
		check_en  = 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_vblank();
		int n;
		n = 0;
		while (!nmi && n < VBL_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!nmi) begin
			$display("Timeout: nmi did not rise within %0d cycles", VBL_TIMEOUT);
			aborted = 1'b1;
		end
	endtask

	// New console type, restarted from reset so the counters start clean
	task automatic select_system(input logic [1:0] s);
		sys_type = sys_type_t'(s);
		reset    = 1'b1;
		repeat (2) @(negedge clk);
		reset    = 1'b0;
	endtask

	task automatic run_step(input logic [3:0] op, input logic [2:0] a, input cpu_byte_t d,
			input logic [15:0] e);
		case (op)
			4'h0, 4'h4: cpu_access(1'b1, op, a, d, e); // Plain write, VRAM bus write
			4'h1, 4'h5: cpu_access(1'b0, op, a, d, e); // Checked read, priming read
			4'h2: wait_vblank();
			4'h3: select_system(d[1:0]);
			default: begin
				$display("Unknown operation %h in the stim file", op);
				aborted = 1'b1;
			end
		endcase
	endtask

	initial begin
		int i;
		ce        = 1'b1;
		reset     = 1'b1;
		sys_type  = SYS_NTSC;
		din       = '0;
		ain       = REG_CTRL;
		read      = 1'b0;
		write     = 1'b0;
		pre_read  = 1'b0;
		pre_write = 1'b0;
		check_en  = 1'b0;
		check_op  = '0;
		check_exp = '0;
		aborted   = 1'b0;
		$readmemh("ppu_core_stim.txt", stim_mem);
		repeat (2) @(negedge clk);
		reset = 1'b0;
		i = 0;
		while (i < STIM_WORDS - 3 && stim_mem[i][3:0] != 4'hF && !aborted) begin
			run_step(stim_mem[i][3:0], stim_mem[i+1][2:0], stim_mem[i+2][7:0], stim_mem[i+3]);
			i = i + 4;
		end
		repeat (4) @(negedge clk); // Let the last read compare finish
		$display("Done: %0d tests, %0d errors, %0d VRAM writes%s", test_count, error_count,
			vram_writes, aborted ? ", run stopped early" : "");
		if (error_count == 0 && !aborted)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* ppu_core_stim.txt */
// Columns in hex: op ain data expected. Ops: 0 write, 1 read and check dout,
// 2 wait for nmi, 3 select system in data with reset, 4 write checked on VRAM bus, 5 read, F end
3 0 00 0000
0 6 3F 0000
0 6 10 0000
0 7 2A 0000
0 6 3F 0000
0 6 00 0000
0 1 C0 0000
1 7 00 00EA
0 6 3F 0000
0 6 00 0000
0 1 41 0000
1 7 00 0060
0 1 00 0000
0 0 00 0000
0 6 21 0000
0 6 08 0000
4 7 5C 2108
4 7 5D 2109
0 0 04 0000
4 7 5E 210A
4 7 5F 212A
0 0 00 0000
0 6 23 0000
0 6 C0 0000
5 7 00 0000
0 6 24 0000
0 6 05 0000
1 7 00 009A
1 7 00 005F
0 6 2A 0000
1 2 00 000A
0 6 22 0000
0 6 33 0000
4 7 77 2233
0 0 80 0000
2 0 00 0000
1 2 00 0080
2 0 00 0000
3 0 01 0000
0 0 80 0000
2 0 00 0000
1 2 00 0080
2 0 00 0000
3 0 02 0000
0 0 80 0000
2 0 00 0000
1 2 00 0080
F 0 00 0000

/* ppu_core.f */
+incdir+.
ppu_timing_pkg.sv
ppu_bus_pkg.sv
frame_timer.sv
vram_addr_reg.sv
palette_ram.sv
ppu_regs.sv
ppu_core.sv
ppu_core_checker.sv
ppu_core_tb.sv

/* Makefile */
# Verilator build and run of the PPU core testbench
LOG = sim.log

all: run

obj_dir/Vppu_core_tb: ppu_core.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f ppu_core.f --top-module ppu_core_tb

run: obj_dir/Vppu_core_tb
	./obj_dir/Vppu_core_tb | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		-f ppu_core.f --top-module ppu_core

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
